//--- qla_pkg.sv
`default_nettype none

package qla_pkg;

    // ----------------------------------------
    // board geometry
    // ----------------------------------------
    localparam int NUM_AXES = 4;
    localparam int CUR_W    = 16;               // dac / adc word width

    // offset binary, zero current sits here
    localparam logic [CUR_W-1:0] CUR_MID       = 16'h8000;
    localparam logic [CUR_W-1:0] SAFETY_MARGIN = 16'd512;  // counts above 2x cmd

    localparam int BUF_DEPTH = 64;
    localparam int BUF_AW    = 6;

    // ----------------------------------------
    // address map
    // ----------------------------------------
    localparam logic [3:0] ADDR_MAIN     = 4'h0;   // board + per-axis regs
    localparam logic [3:0] ADDR_DATA_BUF = 4'hD;   // feedback buffer

    // channel 0 offsets
    localparam logic [3:0] REG_STATUS   = 4'd0;
    localparam logic [3:0] REG_BOARD_ID = 4'd1;

    // channel 1..4 offsets
    localparam logic [3:0] OFF_DAC_CTRL = 4'd0;
    localparam logic [3:0] OFF_ADC_DATA = 4'd1;

    // data buffer indices
    localparam logic [11:0] BUF_CTRL = 12'd0;
    localparam logic [11:0] BUF_DATA = 12'd1;   // read pops

    // ----------------------------------------
    // bus and sample types
    // ----------------------------------------
    typedef struct packed {
        logic [15:0] paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // main space: space / pad / chan / off
    typedef struct packed {
        logic [3:0] space;
        logic [3:0] pad;
        logic [3:0] chan;     // 0 = board, 1..4 = axis
        logic [3:0] off;
    } reg_main_t;

    // buffer space: space / flat index
    typedef struct packed {
        logic [3:0]  space;
        logic [11:0] index;
    } reg_buf_t;

    typedef union packed {
        reg_main_t main_view;
        reg_buf_t  buf_view;
    } reg_addr_u;

    typedef logic [NUM_AXES-1:0][CUR_W-1:0] cur_vec_t;

    typedef struct packed {
        logic     valid;      // one cycle per frame
        cur_vec_t cur;        // raw feedback words
        cur_vec_t mag;        // distance from midscale
    } fb_sample_t;

    typedef struct packed {
        logic       run;
        logic [1:0] chan;     // axis being recorded
        logic       clear;    // single-cycle
    } buf_cfg_t;

    // distance of an offset-binary word from zero current
    function automatic logic [CUR_W-1:0] cur_mag(input logic [CUR_W-1:0] code);
        if (code >= CUR_MID)
            return code - CUR_MID;
        else
            return CUR_MID - code;
    endfunction

endpackage

`default_nettype wire

//--- adc_frontend.sv
`timescale 1ns/100ps
`default_nettype none

module adc_frontend import qla_pkg::*; (
    input  wire logic     sysclk,
    input  wire logic     rst_n,
    input  wire logic     adc_valid,
    input  wire cur_vec_t adc_frame,
    output fb_sample_t    fb
);

    // ----------------------------------------
    // frame capture
    // ----------------------------------------
    logic     valid_q;      // strobe one cycle after the frame edge
    cur_vec_t cur_q;        // latched feedback words
    cur_vec_t mag_q;        // per-axis magnitude

    // one strobe per latched frame
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= adc_valid;
        end
    end

    // hold the last frame until the next one arrives
    always_ff @(posedge sysclk) begin
        if (adc_valid) begin
            cur_q <= adc_frame;
            for (int i = 0; i < NUM_AXES; i++) begin
                mag_q[i] <= cur_mag(adc_frame[i]);   // same edge as the raw word
            end
        end
    end

    // ----------------------------------------
    // outgoing sample
    // ----------------------------------------
    // safety check, buffer and readback all see this one copy
    assign fb = '{valid: valid_q, cur: cur_q, mag: mag_q};

endmodule

`default_nettype wire

//--- safety_check.sv
`timescale 1ns/100ps
`default_nettype none

module safety_check import qla_pkg::*; (
    input  wire logic                sysclk,
    input  wire logic                rst_n,
    input  wire fb_sample_t          fb,
    input  wire cur_vec_t            cmd,
    input  wire logic [NUM_AXES-1:0] clear_trip,
    output logic      [NUM_AXES-1:0] amp_disable
);

    // ----------------------------------------
    // limit compare
    // ----------------------------------------
    logic [NUM_AXES-1:0][CUR_W:0]   cmd_x2;   // 2x command magnitude, one bit wider
    logic [NUM_AXES-1:0][CUR_W+1:0] limit;    // plus margin
    logic [NUM_AXES-1:0]            over;     // trip request this cycle

    always_comb begin
        for (int i = 0; i < NUM_AXES; i++) begin
            cmd_x2[i] = {cur_mag(cmd[i]), 1'b0};
            limit[i]  = {1'b0, cmd_x2[i]} + {2'b00, SAFETY_MARGIN};
            // only judge a fresh frame
            over[i]   = fb.valid && ({2'b00, fb.mag[i]} > limit[i]);
        end
    end

    // ----------------------------------------
    // disable latch
    // ----------------------------------------
    // a trip in the same cycle beats the host clear
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            amp_disable <= '0;
        end else begin
            amp_disable <= (amp_disable & ~clear_trip) | over;
        end
    end

endmodule

`default_nettype wire

//--- data_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module data_buffer import qla_pkg::*; (
    input  wire logic             sysclk,
    input  wire logic             rst_n,
    input  wire fb_sample_t       fb,
    input  wire buf_cfg_t         cfg,
    input  wire logic             pop,
    output logic      [CUR_W-1:0] head,
    output logic      [BUF_AW:0]  count,
    output logic                  overflow
);

    // ----------------------------------------
    // storage and pointers
    // ----------------------------------------
    logic [CUR_W-1:0]  mem [BUF_DEPTH];
    logic [BUF_AW-1:0] wr_ptr;
    logic [BUF_AW-1:0] rd_ptr;
    logic [BUF_AW:0]   cnt;
    logic              empty;
    logic              full;
    logic              push_req;      // sample offered while running
    logic              do_push;
    logic              do_pop;

    assign empty    = (cnt == '0);
    assign full     = (cnt == (BUF_AW+1)'(BUF_DEPTH));
    assign push_req = fb.valid & cfg.run;
    assign do_push  = push_req & ~full;     // full drops the sample
    assign do_pop   = pop & ~empty;         // empty pop is a no-op

    // sample lands on the edge that ends the valid cycle
    always_ff @(posedge sysclk) begin
        if (do_push && !cfg.clear) begin
            mem[wr_ptr] <= fb.cur[cfg.chan];
        end
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            cnt      <= '0;
            overflow <= 1'b0;
        end else if (cfg.clear) begin
            wr_ptr   <= '0;      // flush everything
            rd_ptr   <= '0;
            cnt      <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;       // both or neither
            endcase
            if (push_req && full) begin
                overflow <= 1'b1;          // sticky
            end
        end
    end

    // ----------------------------------------
    // show-ahead output
    // ----------------------------------------
    assign head  = empty ? '0 : mem[rd_ptr];
    assign count = cnt;

endmodule

`default_nettype wire

//--- host_regs.sv
`timescale 1ns/100ps
`default_nettype none

module host_regs import qla_pkg::*; (
    input  wire logic                sysclk,
    input  wire logic                rst_n,
    input  wire apb_req_t            apb_req,
    output apb_rsp_t                 apb_rsp,
    input  wire logic [3:0]          board_id,
    input  wire fb_sample_t          fb,
    input  wire logic [NUM_AXES-1:0] amp_disable,
    input  wire logic [CUR_W-1:0]    head,
    input  wire logic [BUF_AW:0]     count,
    input  wire logic                overflow,
    output cur_vec_t                 cmd,
    output logic      [NUM_AXES-1:0] amp_en,
    output logic      [NUM_AXES-1:0] clear_trip,
    output buf_cfg_t                 cfg,
    output logic                     pop
);

    // ----------------------------------------
    // address decode
    // ----------------------------------------
    reg_addr_u           addr;
    logic                acc;           // apb access phase
    logic                sp_main;
    logic                sp_buf;
    logic                in_map;
    logic                wr_en;
    logic                rd_en;
    logic                status_wr;
    logic [1:0]          axis;          // chan 1..4 -> 0..3
    logic [NUM_AXES-1:0] amp_req;       // host enable mask
    logic                buf_run;
    logic [1:0]          buf_chan;
    logic [31:0]         rdata;

    assign addr    = apb_req.paddr;
    assign acc     = apb_req.psel & apb_req.penable;
    assign sp_main = (addr.main_view.space == ADDR_MAIN);
    assign sp_buf  = (addr.buf_view.space == ADDR_DATA_BUF);
    assign in_map  = (sp_main && addr.main_view.pad == 4'd0 &&
                      addr.main_view.chan <= NUM_AXES) || sp_buf;
    assign wr_en   = acc & apb_req.pwrite & in_map;
    assign rd_en   = acc & ~apb_req.pwrite & in_map;
    assign axis    = 2'(addr.main_view.chan - 4'd1);

    assign status_wr = wr_en && sp_main && addr.main_view.chan == 4'd0 &&
                       addr.main_view.off == REG_STATUS;

    // ----------------------------------------
    // strobes and outputs
    // ----------------------------------------
    assign clear_trip = status_wr ? apb_req.pwdata[NUM_AXES-1:0] : '0;  // re-arm axes
    assign amp_en     = amp_req & ~amp_disable;
    assign pop        = rd_en && sp_buf && addr.buf_view.index == BUF_DATA;
    assign cfg.run    = buf_run;
    assign cfg.chan   = buf_chan;
    assign cfg.clear  = wr_en && sp_buf && addr.buf_view.index == BUF_CTRL &&
                        apb_req.pwdata[3];

    // ----------------------------------------
    // write side
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            cmd      <= {NUM_AXES{CUR_MID}};   // zero current
            amp_req  <= '0;
            buf_run  <= 1'b0;
            buf_chan <= 2'd0;
        end else if (wr_en) begin
            if (status_wr) begin
                amp_req <= apb_req.pwdata[NUM_AXES-1:0];
            end
            if (sp_main && addr.main_view.chan != 4'd0 &&
                addr.main_view.off == OFF_DAC_CTRL) begin
                cmd[axis] <= apb_req.pwdata[CUR_W-1:0];
            end
            if (sp_buf && addr.buf_view.index == BUF_CTRL) begin
                buf_run  <= apb_req.pwdata[0];
                buf_chan <= apb_req.pwdata[2:1];
            end
        end
    end

    // ----------------------------------------
    // read mux, zero for unused offsets
    // ----------------------------------------
    always_comb begin
        rdata = '0;
        if (in_map && sp_main) begin
            if (addr.main_view.chan == 4'd0) begin
                case (addr.main_view.off)
                    REG_STATUS:   rdata[7:0] = {amp_disable, amp_req};
                    REG_BOARD_ID: rdata[3:0] = board_id;
                    default:      rdata = '0;
                endcase
            end else begin
                case (addr.main_view.off)
                    OFF_DAC_CTRL: rdata[CUR_W-1:0] = cmd[axis];
                    OFF_ADC_DATA: rdata[CUR_W-1:0] = fb.cur[axis];   // last frame
                    default:      rdata = '0;
                endcase
            end
        end else if (in_map && sp_buf) begin
            case (addr.buf_view.index)
                BUF_CTRL: begin
                    rdata[0]     = buf_run;
                    rdata[2:1]   = buf_chan;
                    rdata[8]     = overflow;
                    rdata[22:16] = count;
                end
                BUF_DATA: rdata[CUR_W-1:0] = head;   // popped at end of access
                default:  rdata = '0;
            endcase
        end
    end

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;              // zero wait states
    assign apb_rsp.pslverr = acc & ~in_map;

endmodule

`default_nettype wire

//--- qla_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module qla_ctrl_top import qla_pkg::*; (
    input  wire logic                sysclk,
    input  wire logic                rst_n,
    input  wire apb_req_t            apb_req,
    output apb_rsp_t                 apb_rsp,
    input  wire logic                adc_valid,
    input  wire cur_vec_t            adc_frame,
    input  wire logic [3:0]          board_id,
    output cur_vec_t                 dac_cmd,
    output logic      [NUM_AXES-1:0] amp_en
);

    // ----------------------------------------
    // internal nets
    // ----------------------------------------
    fb_sample_t          fb;
    logic [NUM_AXES-1:0] clear_trip;
    logic [NUM_AXES-1:0] amp_disable;
    buf_cfg_t            cfg;
    logic                pop;
    logic [CUR_W-1:0]    head;
    logic [BUF_AW:0]     count;
    logic                overflow;

    // adc frame -> feedback sample
    adc_frontend u_adc (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .adc_valid (adc_valid),
        .adc_frame (adc_frame),
        .fb        (fb)
    );

    // overcurrent trip per axis
    safety_check u_safe (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .fb          (fb),
        .cmd         (dac_cmd),
        .clear_trip  (clear_trip),
        .amp_disable (amp_disable)
    );

    data_buffer u_buf (
        .sysclk   (sysclk),
        .rst_n    (rst_n),
        .fb       (fb),
        .cfg      (cfg),
        .pop      (pop),
        .head     (head),
        .count    (count),
        .overflow (overflow)
    );

    // apb register block, drives the dac words directly
    host_regs u_regs (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .board_id    (board_id),
        .fb          (fb),
        .amp_disable (amp_disable),
        .head        (head),
        .count       (count),
        .overflow    (overflow),
        .cmd         (dac_cmd),
        .amp_en      (amp_en),
        .clear_trip  (clear_trip),
        .cfg         (cfg),
        .pop         (pop)
    );

endmodule

`default_nettype wire

//--- tb_qla_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tb_qla_ctrl import qla_pkg::*; ();

    // ----------------------------------------
    // run length and timeout
    // ----------------------------------------
    localparam int N_CMD    = 3;               // command rounds per axis
    localparam int N_FRAMES = 6;
    localparam int N_TRIP   = 10;
    localparam int N_BUF    = 8;               // short record run
    localparam int N_FILL   = BUF_DEPTH + 3;   // runs past full
    localparam int N_BAD    = 4;
    // bus ops and frames over all tests at about 4 cycles each
    localparam int OPS = 2*NUM_AXES*N_CMD + N_FRAMES*(1+NUM_AXES) + 1 +
                         1 + (NUM_AXES+2) + N_TRIP*(NUM_AXES+3) +
                         2*N_BUF + N_FILL + 10 + 2*N_BAD + 8;
    localparam int MAX_CYCLES = 8*OPS + 40;    // 2x slack

    logic                sysclk;
    logic                rst_n;
    apb_req_t            apb_req;
    apb_rsp_t            apb_rsp;
    logic                adc_valid;
    cur_vec_t            adc_frame;
    logic [3:0]          board_id;
    cur_vec_t            dac_cmd;
    logic [NUM_AXES-1:0] amp_en;

    integer seed     = 32'haf9b_2a36;
    int     n_checks = 0;
    int     n_errors = 0;
    int     err_mark = 0;                      // errors at start of current test
    int     cycles   = 0;

    // model state
    cur_vec_t            m_cmd;
    logic [NUM_AXES-1:0] m_req;                // host enable mask
    logic [NUM_AXES-1:0] m_dis;                // latched trips
    logic [CUR_W-1:0]    m_buf[$];
    logic                m_run;
    logic [1:0]          m_chan;
    logic                m_ovf;

    qla_ctrl_top UUT (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .adc_valid (adc_valid),
        .adc_frame (adc_frame),
        .board_id  (board_id),
        .dac_cmd   (dac_cmd),
        .amp_en    (amp_en)
    );

    always #10 sysclk = ~sysclk;               // 20 ns period

    always @(posedge sysclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    // offset binary distance from zero current
    function automatic int dist_mid(input logic [CUR_W-1:0] w);
        int v;
        int mid;
        v   = int'(w);
        mid = int'(CUR_MID);
        if (v >= mid)
            return v - mid;
        else
            return mid - v;
    endfunction

    function automatic logic [15:0] main_addr(input int chan, input logic [3:0] off);
        return {ADDR_MAIN, 4'h0, 4'(chan), off};
    endfunction

    function automatic logic [15:0] buf_addr(input logic [11:0] index);
        return {ADDR_DATA_BUF, index};
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            n_errors++;
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s finished with %0d errors", name, n_errors - err_mark);
        err_mark = n_errors;
    endtask

    // setup and access cycles with outputs sampled on the falling edge
    task automatic apb_write(input logic [15:0] a, input logic [31:0] d, output logic err);
        apb_req_t req;
        req         = '0;
        req.paddr   = a;
        req.psel    = 1'b1;
        req.pwrite  = 1'b1;
        req.pwdata  = d;
        @(posedge sysclk);
        apb_req <= req;
        req.penable = 1'b1;
        @(posedge sysclk);
        apb_req <= req;
        @(negedge sysclk);
        err = apb_rsp.pslverr;
        compare("pready", apb_rsp.pready, 1);
        @(posedge sysclk);                     // access completes here
        apb_req <= '0;
        @(negedge sysclk);
    endtask

    task automatic apb_read(input logic [15:0] a, output logic [31:0] d, output logic err);
        apb_req_t req;
        req         = '0;
        req.paddr   = a;
        req.psel    = 1'b1;
        @(posedge sysclk);
        apb_req <= req;
        req.penable = 1'b1;
        @(posedge sysclk);
        apb_req <= req;
        @(negedge sysclk);
        d   = apb_rsp.prdata;                  // combinational in access cycle
        err = apb_rsp.pslverr;
        compare("pready", apb_rsp.pready, 1);
        @(posedge sysclk);
        apb_req <= '0;
        @(negedge sysclk);
    endtask

    // one frame through the front end and the model's trip and record rules
    task automatic send_frame(input cur_vec_t f);
        @(posedge sysclk);
        adc_valid <= 1'b1;
        adc_frame <= f;
        @(posedge sysclk);                     // frame latched
        adc_valid <= 1'b0;
        @(posedge sysclk);                     // trip and buffer write
        @(negedge sysclk);
        for (int i = 0; i < NUM_AXES; i++) begin
            if (dist_mid(f[i]) > 2*dist_mid(m_cmd[i]) + int'(SAFETY_MARGIN))
                m_dis[i] = 1'b1;
        end
        if (m_run) begin
            if (m_buf.size() < BUF_DEPTH)
                m_buf.push_back(f[m_chan]);
            else
                m_ovf = 1'b1;                  // dropped and flagged
        end
        compare("amp_en", amp_en, m_req & ~m_dis);
    endtask

    task automatic write_status(input logic [NUM_AXES-1:0] mask);
        logic err;
        apb_write(main_addr(0, REG_STATUS), {28'b0, mask}, err);
        m_req = mask;
        m_dis = m_dis & ~mask;                 // set bits re-arm
        compare("pslverr", err, 0);
        compare("amp_en", amp_en, m_req & ~m_dis);
    endtask

    task automatic verify_status();
        logic [31:0] rd;
        logic        err;
        apb_read(main_addr(0, REG_STATUS), rd, err);
        compare("pslverr", err, 0);
        compare("status", rd, {24'b0, m_dis, m_req});
    endtask

    task automatic verify_buf_ctrl();
        logic [31:0] exp;
        logic [31:0] rd;
        logic        err;
        exp        = '0;
        exp[0]     = m_run;
        exp[2:1]   = m_chan;
        exp[8]     = m_ovf;
        exp[22:16] = 7'(m_buf.size());
        apb_read(buf_addr(BUF_CTRL), rd, err);
        compare("pslverr", err, 0);
        compare("buf_ctrl", rd, exp);
    endtask

    task automatic pop_check();
        logic [31:0] exp;
        logic [31:0] rd;
        logic        err;
        exp = '0;                              // empty pop reads zero
        if (m_buf.size() > 0)
            exp = {16'b0, m_buf.pop_front()};
        apb_read(buf_addr(BUF_DATA), rd, err);
        compare("pslverr", err, 0);
        compare("buf_data", rd, exp);
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        logic [31:0]          w;
        logic [31:0]          rd;
        logic                 err;
        cur_vec_t             f;
        logic [1:0]           ch;
        logic [15:0]          bad [N_BAD];
        sysclk    = 1'b0;
        rst_n     = 1'b0;
        apb_req   = '0;
        adc_valid = 1'b0;
        adc_frame = '0;
        board_id  = 4'($random(seed));
        m_cmd     = {NUM_AXES{CUR_MID}};
        m_req     = '0;
        m_dis     = '0;
        m_run     = 1'b0;
        m_chan    = 2'd0;
        m_ovf     = 1'b0;
        repeat (5) @(posedge sysclk);
        rst_n <= 1'b1;
        @(negedge sysclk);

        // reset state and random commands per axis
        compare("amp_en", amp_en, 0);
        for (int a = 0; a < NUM_AXES; a++)
            compare("dac_cmd", dac_cmd[a], CUR_MID);
        for (int r = 0; r < N_CMD; r++) begin
            for (int a = 0; a < NUM_AXES; a++) begin
                w = $random(seed);
                apb_write(main_addr(a+1, OFF_DAC_CTRL), w, err);
                m_cmd[a] = w[CUR_W-1:0];       // upper bits ignored
                compare("pslverr", err, 0);
                compare("dac_cmd", dac_cmd[a], m_cmd[a]);
                apb_read(main_addr(a+1, OFF_DAC_CTRL), rd, err);
                compare("dac_ctrl", rd, {16'b0, m_cmd[a]});
            end
        end
        report_test("reset and commands");

        // feedback readback and board id
        for (int n = 0; n < N_FRAMES; n++) begin
            f = {$random(seed), $random(seed)};
            send_frame(f);
            for (int a = 0; a < NUM_AXES; a++) begin
                apb_read(main_addr(a+1, OFF_ADC_DATA), rd, err);
                compare("adc_data", rd, {16'b0, f[a]});
            end
        end
        apb_read(main_addr(0, REG_BOARD_ID), rd, err);
        compare("board_id", rd, {28'b0, board_id});
        report_test("feedback readback");

        // safety trip with all axes enabled
        write_status(4'hF);
        // full-scale negative command where twice the magnitude needs the extra bit
        for (int a = 0; a < NUM_AXES; a++) begin
            m_cmd[a] = 16'h0000;
            apb_write(main_addr(a+1, OFF_DAC_CTRL), 32'h0, err);
            compare("dac_cmd", dac_cmd[a], m_cmd[a]);
        end
        send_frame('0);                        // full-scale feedback stays under the limit
        verify_status();
        for (int n = 0; n < N_TRIP; n++) begin
            for (int a = 0; a < NUM_AXES; a++) begin
                w = $random(seed);
                // small commands either side of midscale give both outcomes
                m_cmd[a] = w[16] ? CUR_MID + w[12:0] : CUR_MID - w[12:0];
                apb_write(main_addr(a+1, OFF_DAC_CTRL), {16'b0, m_cmd[a]}, err);
                compare("dac_cmd", dac_cmd[a], m_cmd[a]);
            end
            send_frame({$random(seed), $random(seed)});
            verify_status();
            write_status(4'hF);                // re-enable tripped axes
        end
        report_test("safety trip");

        // data buffer record, readback, overflow
        ch = 2'($random(seed));
        apb_write(buf_addr(BUF_CTRL), {28'b0, 1'b1, ch, 1'b1}, err);   // clear + run
        m_buf.delete();
        m_ovf  = 1'b0;
        m_run  = 1'b1;
        m_chan = ch;
        for (int n = 0; n < N_BUF; n++)
            send_frame({$random(seed), $random(seed)});
        verify_buf_ctrl();
        for (int n = 0; n < N_BUF; n++)
            pop_check();
        pop_check();                           // empty now
        verify_buf_ctrl();
        for (int n = 0; n < N_FILL; n++)
            send_frame({$random(seed), $random(seed)});
        verify_buf_ctrl();
        pop_check();
        verify_buf_ctrl();                     // overflow still set
        apb_write(buf_addr(BUF_CTRL), 32'h8, err);   // clear with run off
        m_buf.delete();
        m_ovf  = 1'b0;
        m_run  = 1'b0;
        m_chan = 2'd0;
        verify_buf_ctrl();
        report_test("data buffer");

        // bus errors outside the map and undefined offsets inside it
        bad[0] = 16'h3000;                     // unknown space
        bad[1] = 16'h0050;                     // channel 5
        bad[2] = 16'h0210;                     // pad not zero
        bad[3] = 16'hF001;
        for (int n = 0; n < N_BAD; n++) begin
            apb_write(bad[n], $random(seed), err);
            compare("pslverr", err, 1);
            apb_read(bad[n], rd, err);
            compare("pslverr", err, 1);
        end
        for (int a = 0; a < NUM_AXES; a++)
            compare("dac_cmd", dac_cmd[a], m_cmd[a]);
        verify_status();
        verify_buf_ctrl();
        apb_read(main_addr(1, 4'h7), rd, err);
        compare("pslverr", err, 0);
        compare("undefined offset", rd, 0);
        apb_read(buf_addr(12'h5), rd, err);
        compare("pslverr", err, 0);
        compare("undefined index", rd, 0);
        report_test("bus errors");

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
qla_pkg.sv
adc_frontend.sv
safety_check.sv
data_buffer.sv
host_regs.sv
qla_ctrl_top.sv
tb_qla_ctrl.sv

//--- Bender.yml
package:
  name: qla_ctrl

sources:
  - qla_pkg.sv
  - adc_frontend.sv
  - safety_check.sv
  - data_buffer.sv
  - host_regs.sv
  - qla_ctrl_top.sv
  - target: test
    files:
      - tb_qla_ctrl.sv
